//--- sim.f
+incdir+rtl
rtl/jit_pkg.sv
rtl/jit_fifo.sv
rtl/jit_decoder.sv
rtl/jit_acc_regs.sv
rtl/jit_done_arbiter.sv
rtl/jit_dispatch.sv
test/jit_dispatch_chk.sv
test/jit_dispatch_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the dispatcher testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module jit_dispatch_tb -f sim.f -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Test failed" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation passed"

//--- test/jit_dispatch_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "jit_cfg.svh"

module jit_dispatch_tb import jit_pkg::*; ();

  localparam int NUM_CMDS   = 200;
  // cycle budget per command, room for drains and report stalls
  localparam int MAX_CYCLES = NUM_CMDS * 20;
  // three cycles per command, fifo words plus one in flight, one cycle fifo latency
  localparam int DRAIN_CYCLES = (`JIT_CMD_DEPTH + 2) * 3 + 2;

  logic                     ACLK;
  logic                     ARESETN;
  logic                     cmd_valid;
  logic                     cmd_ready;
  cmd_t                     cmd_data;
  logic                     rpt_valid;
  logic                     rpt_ready = 1'b0;
  rpt_t                     rpt_data;
  nib_t [`JIT_NUM_ACC-1:0]  acc_a;
  nib_t [`JIT_NUM_ACC-1:0]  acc_b;
  nib_t [`JIT_NUM_ACC-1:0]  acc_c;
  val_t [`JIT_NUM_ACC-1:0]  acc_r1;
  val_t [`JIT_NUM_ACC-1:0]  acc_r2;
  val_t [`JIT_NUM_ACC-1:0]  acc_r3;
  logic [`JIT_NUM_ACC-1:0]  acc_start;
  logic [`JIT_NUM_ACC-1:0]  acc_done = '0;

  // reference model, written by the stimulus process only
  nib_t exp_a [`JIT_NUM_ACC];
  nib_t exp_b [`JIT_NUM_ACC];
  nib_t exp_c [`JIT_NUM_ACC];
  val_t exp_r [`JIT_NUM_ACC][`JIT_NUM_REG];
  int   exp_starts [`JIT_NUM_ACC];
  // responder and report sink state
  int   seen_starts [`JIT_NUM_ACC];
  int   pend [`JIT_NUM_ACC];
  int   wait_cnt [`JIT_NUM_ACC];
  int   done_cnt [`JIT_NUM_ACC];
  int   rpt_cnt [`JIT_NUM_ACC];
  int   stall_left;
  // error counters, one per process
  int   main_errs = 0;
  int   rpt_errs = 0;
  int   cycles = 0;

  jit_dispatch jit_dispatch_i (
    .ACLK(ACLK), .ARESETN(ARESETN),
    .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_data(cmd_data),
    .rpt_valid(rpt_valid), .rpt_ready(rpt_ready), .rpt_data(rpt_data),
    .acc_a(acc_a), .acc_b(acc_b), .acc_c(acc_c),
    .acc_r1(acc_r1), .acc_r2(acc_r2), .acc_r3(acc_r3),
    .acc_start(acc_start), .acc_done(acc_done)
  );

  bind jit_dispatch jit_dispatch_chk jit_dispatch_chk_i (
    .ACLK(ACLK), .ARESETN(ARESETN), .acc_start(acc_start),
    .rpt_valid(rpt_valid), .rpt_ready(rpt_ready), .rpt_data(rpt_data)
  );

  initial begin
    ACLK = 1'b0;
    forever #2 ACLK = ~ACLK;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  // mismatch bumps the caller's counter
  task automatic compare(input string name, input logic [31:0] exp,
                         input logic [31:0] act, inout int errs);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      errs++;
    end
  endtask

  // c nibble, low pair from a and high pair from b
  function automatic nib_t c_rule(input nib_t a, input nib_t b);
    nib_t c;
    c[1:0] = (a == 4'h0) ? 2'b01 : 2'b10;
    c[3:2] = (b == 4'h0) ? 2'b01 : 2'b10;
    return c;
  endfunction

  function automatic cmd_t make_command();
    cmd_t w;
    int   kind;
    w    = $urandom;
    kind = $urandom_range(7, 0);
    case (kind)
      0, 1:    w[31:28] = `JIT_OP_START;
      2, 3:    w[31:28] = `JIT_OP_CFG;
      4, 5:    w[31:28] = `JIT_OP_REG;
      // 0..9 never hits a known opcode
      default: w[31:28] = 4'($urandom_range(9, 0));
    endcase
    // 0 and N+1 are out of range
    w[27:24] = 4'($urandom_range(`JIT_NUM_ACC + 1, 0));
    w[23:20] = 4'($urandom_range(4, 0));
    return w;
  endfunction

  task automatic apply_model(input cmd_t w);
    int idx;
    int rn;
    idx = int'(w[27:24]) - 1;
    rn  = int'(w[23:20]);
    if (idx >= 0 && idx < `JIT_NUM_ACC) begin
      case (w[31:28])
        `JIT_OP_START: begin
          exp_starts[idx]++;
        end
        `JIT_OP_CFG: begin
          exp_a[idx] = w[3:0];
          exp_b[idx] = w[7:4];
          exp_c[idx] = c_rule(w[3:0], w[7:4]);
        end
        `JIT_OP_REG: begin
          if (rn >= 1 && rn <= `JIT_NUM_REG) begin
            exp_r[idx][rn-1] = w[15:0];
          end
        end
        default: begin
        end
      endcase
    end
  endtask

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic send_command(input cmd_t w);
    cmd_valid = 1'b1;
    cmd_data  = w;
    // cmd_ready only moves on rising edges
    while (!cmd_ready) @(negedge ACLK);
    @(negedge ACLK);
    cmd_valid = 1'b0;
  endtask

  task automatic check_regs();
    for (int i = 0; i < `JIT_NUM_ACC; i++) begin
      compare($sformatf("acc_a[%0d]", i), 32'(exp_a[i]), 32'(acc_a[i]), main_errs);
      compare($sformatf("acc_b[%0d]", i), 32'(exp_b[i]), 32'(acc_b[i]), main_errs);
      compare($sformatf("acc_c[%0d]", i), 32'(exp_c[i]), 32'(acc_c[i]), main_errs);
      compare($sformatf("acc_r1[%0d]", i), 32'(exp_r[i][0]), 32'(acc_r1[i]), main_errs);
      compare($sformatf("acc_r2[%0d]", i), 32'(exp_r[i][1]), 32'(acc_r2[i]), main_errs);
      compare($sformatf("acc_r3[%0d]", i), 32'(exp_r[i][2]), 32'(acc_r3[i]), main_errs);
    end
  endtask

  // no start waiting, no done pending, every done reported
  function automatic bit quiet();
    for (int i = 0; i < `JIT_NUM_ACC; i++) begin
      if (pend[i] != 0 || wait_cnt[i] != 0 || done_cnt[i] != rpt_cnt[i]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic take_report();
    int idx;
    idx = int'(rpt_data.acc) - 1;
    compare("rpt_data.tag", 32'(`JIT_DONE_TAG), 32'(rpt_data.tag), rpt_errs);
    if (idx < 0 || idx >= `JIT_NUM_ACC) begin
      $display("report at %0t names accelerator %0d, which does not exist",
               $time, rpt_data.acc);
      rpt_errs++;
    end else begin
      if (rpt_cnt[idx] >= done_cnt[idx]) begin
        $display("report at %0t from accelerator %0d without a done behind it",
                 $time, idx + 1);
        rpt_errs++;
      end
      rpt_cnt[idx]++;
    end
  endtask

  // ----------------------------------------------------------------------
  // accelerator responder and report sink, all on the falling edge
  // ----------------------------------------------------------------------
  always @(negedge ACLK) begin
    if (!ARESETN) begin
      rpt_ready  = 1'b0;
      acc_done   = '0;
      stall_left = 0;
      for (int i = 0; i < `JIT_NUM_ACC; i++) begin
        seen_starts[i] = 0;
        pend[i]        = 0;
        wait_cnt[i]    = 0;
        done_cnt[i]    = 0;
        rpt_cnt[i]     = 0;
      end
    end else begin
      // mostly ready, now and then a long stall
      if (stall_left > 0) begin
        rpt_ready  = 1'b0;
        stall_left = stall_left - 1;
      end else if ($urandom_range(63, 0) == 0) begin
        rpt_ready  = 1'b0;
        stall_left = $urandom_range(60, 20);
      end else begin
        rpt_ready = ($urandom_range(3, 0) != 0);
      end
      // transfer happens on the coming rising edge
      if (rpt_valid && rpt_ready) begin
        take_report();
      end
      for (int i = 0; i < `JIT_NUM_ACC; i++) begin
        acc_done[i] = 1'b0;
        if (acc_start[i]) begin
          seen_starts[i]++;
          pend[i]++;
        end
        if (wait_cnt[i] == 0 && pend[i] > 0) begin
          pend[i]--;
          wait_cnt[i] = $urandom_range(8, 1);
        end else if (wait_cnt[i] > 1) begin
          wait_cnt[i]--;
        end else if (wait_cnt[i] == 1 && done_cnt[i] == rpt_cnt[i]) begin
          // only with no earlier report outstanding, so dones never merge
          acc_done[i] = 1'b1;
          done_cnt[i]++;
          wait_cnt[i] = 0;
        end
      end
    end
  end

  // run limit
  always @(posedge ACLK) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      $display("%0d model mismatches, %0d report errors, 1 timeout", main_errs, rpt_errs);
      $display("Test failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  initial begin
    cmd_t word;
    void'($urandom(32'h58f0ce68));
    ARESETN   = 1'b0;
    cmd_valid = 1'b0;
    cmd_data  = '0;
    for (int i = 0; i < `JIT_NUM_ACC; i++) begin
      exp_a[i]      = '0;
      exp_b[i]      = '0;
      exp_c[i]      = '0;
      exp_starts[i] = 0;
      for (int j = 0; j < `JIT_NUM_REG; j++) begin
        exp_r[i][j] = '0;
      end
    end
    repeat (4) @(posedge ACLK);
    @(negedge ACLK);
    ARESETN = 1'b1;
    @(negedge ACLK);

    // state right after reset
    compare("cmd_ready", 32'd1, 32'(cmd_ready), main_errs);
    compare("rpt_valid", 32'd0, 32'(rpt_valid), main_errs);
    compare("acc_start", 32'd0, 32'(acc_start), main_errs);
    check_regs();

    for (int n = 0; n < NUM_CMDS; n++) begin
      word = make_command();
      send_command(word);
      apply_model(word);
      // configure results checked once the stream is idle
      if (word[31:28] == `JIT_OP_CFG) begin
        repeat (DRAIN_CYCLES) @(negedge ACLK);
        check_regs();
      end
    end
    repeat (DRAIN_CYCLES) @(negedge ACLK);
    check_regs();

    // let pending dones and reports finish
    @(posedge ACLK);
    while (!quiet()) @(posedge ACLK);
    @(negedge ACLK);
    compare("rpt_valid", 32'd0, 32'(rpt_valid), main_errs);
    for (int i = 0; i < `JIT_NUM_ACC; i++) begin
      compare($sformatf("start count acc %0d", i + 1),
              32'(exp_starts[i]), 32'(seen_starts[i]), main_errs);
      compare($sformatf("report count acc %0d", i + 1),
              32'(done_cnt[i]), 32'(rpt_cnt[i]), main_errs);
    end

    $display("%0d model mismatches, %0d report errors", main_errs, rpt_errs);
    if (main_errs == 0 && rpt_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/jit_dispatch_chk.sv
`timescale 1ns/100ps
`default_nettype none

`include "jit_cfg.svh"

module jit_dispatch_chk import jit_pkg::*; (
  input wire                     ACLK,
  input wire                     ARESETN,
  input wire [`JIT_NUM_ACC-1:0]  acc_start,
  input wire                     rpt_valid,
  input wire                     rpt_ready,
  input wire rpt_t               rpt_data
);

  // ----------------------------------------------------------------------
  // start pulses
  // ----------------------------------------------------------------------
  // one accelerator per command
  start_onehot: assert property (@(posedge ACLK) disable iff (!ARESETN)
    $onehot0(acc_start))
    else $error("more than one acc_start bit set");

  // commands are three cycles apart, so a pulse never repeats back to back
  start_single: assert property (@(posedge ACLK) disable iff (!ARESETN)
    (|acc_start) |=> (acc_start == '0))
    else $error("acc_start held for more than one cycle");

  // stalled report holds valid and data
  rpt_hold: assert property (@(posedge ACLK) disable iff (!ARESETN)
    (rpt_valid && !rpt_ready) |=> (rpt_valid && $stable(rpt_data)))
    else $error("report channel changed while stalled");

endmodule

`default_nettype wire

//--- rtl/jit_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

`include "jit_cfg.svh"

module jit_dispatch import jit_pkg::*; (
  input  wire                      ACLK,
  input  wire                      ARESETN,
  // command channel
  input  wire                      cmd_valid,
  output logic                     cmd_ready,
  input  wire cmd_t                cmd_data,
  // report channel
  output logic                     rpt_valid,
  input  wire                      rpt_ready,
  output rpt_t                     rpt_data,
  // accelerators
  output nib_t [`JIT_NUM_ACC-1:0]  acc_a,
  output nib_t [`JIT_NUM_ACC-1:0]  acc_b,
  output nib_t [`JIT_NUM_ACC-1:0]  acc_c,
  output val_t [`JIT_NUM_ACC-1:0]  acc_r1,
  output val_t [`JIT_NUM_ACC-1:0]  acc_r2,
  output val_t [`JIT_NUM_ACC-1:0]  acc_r3,
  output logic [`JIT_NUM_ACC-1:0]  acc_start,
  input  wire  [`JIT_NUM_ACC-1:0]  acc_done
);

  // command path
  logic     q_valid;
  cmd_t     q_data;
  logic     cmd_pop;
  logic     op_strobe;
  op_e      op;
  acc_num_t acc_num;
  reg_num_t reg_num;
  val_t     value;
  nib_t     nib_a;
  nib_t     nib_b;
  // completion path
  logic     rpt_push;
  rpt_t     rpt_word;
  logic     rpt_full;

  // -------------------------------------------------------------------
  // command side
  // -------------------------------------------------------------------
  jit_fifo #(.payload_t(cmd_t), .DEPTH(`JIT_CMD_DEPTH)) cmd_fifo (
    .ACLK(ACLK), .ARESETN(ARESETN),
    .in_valid(cmd_valid), .in_ready(cmd_ready), .in_data(cmd_data),
    .out_valid(q_valid), .out_ready(cmd_pop), .out_data(q_data),
    .full()
  );

  jit_decoder jit_decoder_i (
    .ACLK(ACLK), .ARESETN(ARESETN),
    .cmd_valid(q_valid), .cmd_data(q_data), .cmd_pop(cmd_pop),
    .op_strobe(op_strobe), .op(op), .acc_num(acc_num), .reg_num(reg_num),
    .value(value), .nib_a(nib_a), .nib_b(nib_b)
  );

  jit_acc_regs jit_acc_regs_i (
    .ACLK(ACLK), .ARESETN(ARESETN),
    .op_strobe(op_strobe), .op(op), .acc_num(acc_num), .reg_num(reg_num),
    .value(value), .nib_a(nib_a), .nib_b(nib_b),
    .acc_a(acc_a), .acc_b(acc_b), .acc_c(acc_c),
    .acc_r1(acc_r1), .acc_r2(acc_r2), .acc_r3(acc_r3),
    .acc_start(acc_start)
  );

  // -------------------------------------------------------------------
  // completion side, push gated by full so in_ready is not needed
  // -------------------------------------------------------------------
  jit_done_arbiter jit_done_arbiter_i (
    .ACLK(ACLK), .ARESETN(ARESETN),
    .acc_done(acc_done), .rpt_full(rpt_full),
    .rpt_push(rpt_push), .rpt_data(rpt_word)
  );

  jit_fifo #(.payload_t(rpt_t), .DEPTH(`JIT_RPT_DEPTH)) rpt_fifo (
    .ACLK(ACLK), .ARESETN(ARESETN),
    .in_valid(rpt_push), .in_ready(), .in_data(rpt_word),
    .out_valid(rpt_valid), .out_ready(rpt_ready), .out_data(rpt_data),
    .full(rpt_full)
  );

endmodule

`default_nettype wire

//--- rtl/jit_done_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "jit_cfg.svh"

module jit_done_arbiter import jit_pkg::*; (
  input  wire                     ACLK,
  input  wire                     ARESETN,
  // done pulses, index 0 is accelerator 1
  input  wire [`JIT_NUM_ACC-1:0]  acc_done,
  // report fifo write side
  input  wire                     rpt_full,
  output logic                    rpt_push,
  output rpt_t                    rpt_data
);

  localparam int PW = (`JIT_NUM_ACC > 1) ? $clog2(`JIT_NUM_ACC) : 1;

  logic [`JIT_NUM_ACC-1:0] done_q;
  logic [`JIT_NUM_ACC-1:0] done_clr;
  logic [PW-1:0]           ptr;
  logic                    pending;

  // -------------------------------------------------------------------
  // scan and push
  // -------------------------------------------------------------------
  assign pending  = done_q[ptr];
  // never push into a full fifo
  assign rpt_push = pending && !rpt_full;

  always_comb begin
    done_clr      = '0;
    done_clr[ptr] = rpt_push;
  end

  // tag plus 1-based number
  assign rpt_data.tag = `JIT_DONE_TAG;
  assign rpt_data.acc = 16'(ptr) + 16'd1;

  // done latches, a pulse during a clear sets it again
  always_ff @(posedge ACLK) begin
    if (!ARESETN) begin
      done_q <= '0;
    end else begin
      done_q <= (done_q & ~done_clr) | acc_done;
    end
  end

  // round robin pointer, holds while its report is blocked
  always_ff @(posedge ACLK) begin
    if (!ARESETN) begin
      ptr <= '0;
    end else if (!(pending && rpt_full)) begin
      ptr <= (ptr == PW'(`JIT_NUM_ACC - 1)) ? '0 : ptr + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/jit_acc_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "jit_cfg.svh"

module jit_acc_regs import jit_pkg::*; (
  input  wire                            ACLK,
  input  wire                            ARESETN,
  // operation from the decoder
  input  wire                            op_strobe,
  input  wire op_e                       op,
  input  wire acc_num_t                  acc_num,
  input  wire reg_num_t                  reg_num,
  input  wire val_t                      value,
  input  wire nib_t                      nib_a,
  input  wire nib_t                      nib_b,
  // per accelerator, index 0 is accelerator 1
  output nib_t [`JIT_NUM_ACC-1:0]        acc_a,
  output nib_t [`JIT_NUM_ACC-1:0]        acc_b,
  output nib_t [`JIT_NUM_ACC-1:0]        acc_c,
  output val_t [`JIT_NUM_ACC-1:0]        acc_r1,
  output val_t [`JIT_NUM_ACC-1:0]        acc_r2,
  output val_t [`JIT_NUM_ACC-1:0]        acc_r3,
  output logic [`JIT_NUM_ACC-1:0]        acc_start
);

  // R1..R3 per accelerator
  val_t [`JIT_NUM_ACC-1:0][`JIT_NUM_REG-1:0] regs;
  logic [`JIT_NUM_ACC-1:0]                   acc_sel;
  nib_t                                      nib_c;

  // one-hot accelerator select, 0 and out of range hit nothing
  always_comb begin
    for (int i = 0; i < `JIT_NUM_ACC; i++) begin
      acc_sel[i] = op_strobe && (acc_num == acc_num_t'(i + 1));
    end
  end

  // c rule, high pair from b and low pair from a
  assign nib_c = {(nib_b == '0) ? 2'b01 : 2'b10,
                  (nib_a == '0) ? 2'b01 : 2'b10};

  always_comb begin
    for (int i = 0; i < `JIT_NUM_ACC; i++) begin
      acc_r1[i] = regs[i][0];
      acc_r2[i] = regs[i][1];
      acc_r3[i] = regs[i][2];
    end
  end

  // -------------------------------------------------------------------
  // register bank, updates on the edge that ends exec
  // -------------------------------------------------------------------
  always_ff @(posedge ACLK) begin
    if (!ARESETN) begin
      acc_a     <= '0;
      acc_b     <= '0;
      acc_c     <= '0;
      regs      <= '0;
      acc_start <= '0;
    end else begin
      // start is a single cycle pulse
      acc_start <= '0;
      for (int i = 0; i < `JIT_NUM_ACC; i++) begin
        if (acc_sel[i]) begin
          case (op)
            START: begin
              acc_start[i] <= 1'b1;
            end
            CFG: begin
              acc_a[i] <= nib_a;
              acc_b[i] <= nib_b;
              acc_c[i] <= nib_c;
            end
            REG: begin
              // register number is 1-based, others ignored
              for (int j = 0; j < `JIT_NUM_REG; j++) begin
                if (reg_num == reg_num_t'(j + 1)) begin
                  regs[i][j] <= value;
                end
              end
            end
            default: begin
            end
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/jit_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "jit_cfg.svh"

module jit_decoder import jit_pkg::*; (
  input  wire       ACLK,
  input  wire       ARESETN,
  // head of command fifo
  input  wire       cmd_valid,
  input  wire cmd_t cmd_data,
  output logic      cmd_pop,
  // operation to the register bank
  output logic      op_strobe,
  output op_e       op,
  output acc_num_t  acc_num,
  output reg_num_t  reg_num,
  output val_t      value,
  output nib_t      nib_a,
  output nib_t      nib_b
);

  typedef enum logic [1:0] {
    S_FETCH,
    S_DECODE,
    S_EXEC
  } state_e;

  state_e state;
  cmd_t   cmd_q;
  op_e    op_q;
  op_e    dec_op;

  // -------------------------------------------------------------------
  // opcode lookup on the captured word
  // -------------------------------------------------------------------
  always_comb begin
    case (cmd_q[`JIT_OP_LSB +: 4])
      `JIT_OP_START: dec_op = START;
      `JIT_OP_CFG:   dec_op = CFG;
      `JIT_OP_REG:   dec_op = REG;
      default:       dec_op = NONE;
    endcase
  end

  // pop only while waiting for a word
  assign cmd_pop   = (state == S_FETCH) && cmd_valid;
  assign op_strobe = (state == S_EXEC);
  assign op        = op_q;

  // field slices, range checks live downstream
  assign acc_num = cmd_q[`JIT_ACC_LSB +: $bits(acc_num_t)];
  assign reg_num = cmd_q[`JIT_REG_LSB +: $bits(reg_num_t)];
  assign value   = cmd_q[`JIT_VAL_LSB +: $bits(val_t)];
  assign nib_a   = cmd_q[`JIT_NIBA_LSB +: $bits(nib_t)];
  assign nib_b   = cmd_q[`JIT_NIBB_LSB +: $bits(nib_t)];

  // command capture
  always_ff @(posedge ACLK) begin
    if (cmd_pop) begin
      cmd_q <= cmd_data;
    end
  end

  // -------------------------------------------------------------------
  // fetch / decode / exec, three cycles per command
  // -------------------------------------------------------------------
  always_ff @(posedge ACLK) begin
    if (!ARESETN) begin
      state <= S_FETCH;
      op_q  <= NONE;
    end else begin
      case (state)
        S_FETCH: begin
          if (cmd_valid) begin
            state <= S_DECODE;
          end
        end
        S_DECODE: begin
          op_q  <= dec_op;
          // unknown opcode drops back without a strobe
          state <= (dec_op == NONE) ? S_FETCH : S_EXEC;
        end
        default: begin
          state <= S_FETCH;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/jit_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module jit_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 2
) (
  input  wire           ACLK,
  input  wire           ARESETN,
  // write side
  input  wire           in_valid,
  output logic          in_ready,
  input  wire payload_t in_data,
  // read side
  output logic          out_valid,
  input  wire           out_ready,
  output payload_t      out_data,
  // for push gating upstream
  output logic          full
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_push;
  logic          do_pop;

  // circular pointer step
  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
    return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign in_ready  = (count != CW'(DEPTH));
  assign full      = !in_ready;
  assign out_valid = (count != '0);
  // head word, valid the cycle after its push
  assign out_data  = mem[rd_ptr];
  assign do_push   = in_valid && in_ready;
  assign do_pop    = out_valid && out_ready;

  always_ff @(posedge ACLK) begin
    if (do_push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // pointers and fill level
  always_ff @(posedge ACLK) begin
    if (!ARESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // simultaneous push and pop keeps the level
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/jit_pkg.sv
`default_nettype none

package jit_pkg;

  // raw command word, fields located by the cfg macros
  typedef logic [31:0] cmd_t;

  // completion report
  typedef struct packed {
    logic [15:0] tag;
    // 1-based accelerator number
    logic [15:0] acc;
  } rpt_t;

  // decoded operation
  typedef enum logic [1:0] {
    NONE,
    START,
    CFG,
    REG
  } op_e;

  // command fields
  typedef logic [3:0]  acc_num_t;
  typedef logic [3:0]  reg_num_t;
  typedef logic [3:0]  nib_t;
  typedef logic [15:0] val_t;

endpackage

`default_nettype wire

//--- rtl/jit_cfg.svh
`ifndef JIT_CFG_SVH
`define JIT_CFG_SVH

// accelerator count, logic holds up to 15
`define JIT_NUM_ACC     2
// number of R registers per accelerator
`define JIT_NUM_REG     3

// fifo depths
`define JIT_CMD_DEPTH   2
`define JIT_RPT_DEPTH   4

// command opcodes
`define JIT_OP_START    4'hA
`define JIT_OP_CFG      4'hB
`define JIT_OP_REG      4'hC

// upper half of every completion word
`define JIT_DONE_TAG    16'hBABE

// command field positions, lsb of each field
`define JIT_OP_LSB      28
`define JIT_ACC_LSB     24
`define JIT_REG_LSB     20
`define JIT_VAL_LSB     0
`define JIT_NIBA_LSB    0
`define JIT_NIBB_LSB    4

`endif
